/* feat_pkg.sv */
//##############################
// feature path definitions
// widths, window and baseline constants
//##############################

package feat_pkg;

	// input sample and accumulator widths
	localparam int sample_w = 16;
	localparam int feat_w = 40;

	// samples per feature window
	localparam int feat_win = 16;
	localparam int win_cnt_w = $clog2(feat_win);

	// baseline moves by 1/8 of the difference per window
	localparam int base_shift = 3;

	// windows before any flag may rise
	localparam int warmup_win = 4;
	localparam int warm_w = $clog2(warmup_win + 1);

	// baselines are kept signed with headroom for the 1.5x compare
	localparam int base_w = feat_w + 2;

	// one window's features
	typedef struct packed {
		logic [feat_w-1:0] ll;
		logic signed [feat_w-1:0] ne;
		logic [feat_w-1:0] pw;
	} feat_vec_t;

	// per-feature flags above baseline
	typedef struct packed {
		logic ll;
		logic ne;
		logic pw;
	} feat_flags_t;

endpackage

/* ctrl_pkg.sv */
//##############################
// control path definitions
// vote weights, stimulation timing
//##############################

package ctrl_pkg;

	// vote weights and threshold
	localparam int w_ll = 3;
	localparam int w_ne = 2;
	localparam int w_pw = 2;
	localparam int vote_thresh = 4;
	localparam int score_w = 3;

	// stimulation and refractory lengths in cycles
	localparam int stim_cyc = 8;
	localparam int refract_cyc = 24;
	localparam int timer_w = 5;

	typedef enum logic [1:0] {
		idle,
		stim,
		refract
	} stim_state_t;

endpackage

/* feature_extract.sv */
//##############################
// window feature extraction
// line length, teager energy, power
//##############################

module feature_extract (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic signed [feat_pkg::sample_w-1:0] sample,
	output feat_pkg::feat_vec_t feat,
	output logic feat_valid
);
	import feat_pkg::*;

	// x[n-1] and x[n-2], kept across windows
	logic signed [sample_w-1:0] x1;
	logic signed [sample_w-1:0] x2;
	logic [win_cnt_w-1:0] cnt;
	logic last;

	logic [feat_w-1:0] acc_ll;
	logic signed [feat_w-1:0] acc_ne;
	logic [feat_w-1:0] acc_pw;

	logic signed [sample_w:0] diff;
	logic [sample_w:0] ll_term;
	logic signed [2*sample_w:0] ne_term;
	logic [2*sample_w-1:0] pw_term;
	logic [feat_w-1:0] sum_ll;
	logic signed [feat_w-1:0] sum_ne;
	logic [feat_w-1:0] sum_pw;

	// per-sample terms and running sums
	always_comb begin
		diff = sample - x1;
		ll_term = (diff < 0) ? -diff : diff;
		ne_term = x1 * x1 - sample * x2;
		pw_term = sample * sample;
		sum_ll = acc_ll + feat_w'(ll_term);
		sum_ne = acc_ne + feat_w'(ne_term);
		sum_pw = acc_pw + feat_w'(pw_term);
	end

	assign last = (cnt == win_cnt_w'(feat_win - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			x1 <= '0;
			x2 <= '0;
			cnt <= '0;
			acc_ll <= '0;
			acc_ne <= '0;
			acc_pw <= '0;
			feat_valid <= 1'b0;
		end else begin
			feat_valid <= en && last;
			if (en) begin
				x1 <= sample;
				x2 <= x1;
				if (last) begin
					cnt <= '0;
					acc_ll <= '0;
					acc_ne <= '0;
					acc_pw <= '0;
				end else begin
					cnt <= cnt + 1'b1;
					acc_ll <= sum_ll;
					acc_ne <= sum_ne;
					acc_pw <= sum_pw;
				end
			end
		end
	end

	// window totals, held until the next window closes
	always_ff @(posedge clk) begin
		if (en && last) begin
			feat.ll <= sum_ll;
			feat.ne <= sum_ne;
			feat.pw <= sum_pw;
		end
	end

endmodule

/* baseline_track.sv */
//##############################
// baseline tracking
// exponential baseline and 1.5x flags
//##############################

module baseline_track (
	input logic clk,
	input logic arst_n,
	input feat_pkg::feat_vec_t feat,
	input logic feat_valid,
	output feat_pkg::feat_flags_t flags,
	output logic flags_valid
);
	import feat_pkg::*;

	logic signed [base_w-1:0] f_ll;
	logic signed [base_w-1:0] f_ne;
	logic signed [base_w-1:0] f_pw;
	logic signed [base_w-1:0] b_ll;
	logic signed [base_w-1:0] b_ne;
	logic signed [base_w-1:0] b_pw;
	logic [warm_w-1:0] win_idx;
	logic warm;

	// feature above 1.5x its baseline
	function automatic logic above(input logic signed [base_w-1:0] f,
			input logic signed [base_w-1:0] b);
		return f > b + (b >>> 1);
	endfunction

	// one exponential smoothing step
	function automatic logic signed [base_w-1:0] step(input logic signed [base_w-1:0] f,
			input logic signed [base_w-1:0] b);
		return b + ((f - b) >>> base_shift);
	endfunction

	always_comb begin
		f_ll = {2'b00, feat.ll};
		f_ne = {{2{feat.ne[feat_w-1]}}, feat.ne};
		f_pw = {2'b00, feat.pw};
	end

	// saturates once warm-up is over
	assign warm = (win_idx == warm_w'(warmup_win));

	// compare against the baseline from before this update
	always_ff @(posedge clk) begin
		if (feat_valid) begin
			flags.ll <= warm && above(f_ll, b_ll);
			flags.ne <= warm && (f_ne > 0) && above(f_ne, b_ne);
			flags.pw <= warm && above(f_pw, b_pw);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_valid <= 1'b0;
			win_idx <= '0;
			b_ll <= '0;
			b_ne <= '0;
			b_pw <= '0;
		end else begin
			flags_valid <= feat_valid;
			if (feat_valid) begin
				if (!warm)
					win_idx <= win_idx + 1'b1;
				b_ll <= step(f_ll, b_ll);
				b_ne <= step(f_ne, b_ne);
				b_pw <= step(f_pw, b_pw);
			end
		end
	end

endmodule

/* feature_vote.sv */
//##############################
// weighted feature vote
// flags to a one-cycle detect
//##############################

module feature_vote (
	input logic clk,
	input logic arst_n,
	input feat_pkg::feat_flags_t flags,
	input logic flags_valid,
	output logic detect
);
	import ctrl_pkg::*;

	logic [score_w-1:0] score;

	// sum of weights of the raised flags
	always_comb begin
		score = '0;
		if (flags.ll)
			score = score + score_w'(w_ll);
		if (flags.ne)
			score = score + score_w'(w_ne);
		if (flags.pw)
			score = score + score_w'(w_pw);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			detect <= 1'b0;
		end else begin
			detect <= flags_valid && (score >= score_w'(vote_thresh));
		end
	end

endmodule

/* stim_timer.sv */
//##############################
// interval timer
// loadable down-counter
//##############################

module stim_timer (
	input logic clk,
	input logic arst_n,
	input logic load,
	input logic [ctrl_pkg::timer_w-1:0] load_val,
	output logic done
);
	import ctrl_pkg::*;

	logic [timer_w-1:0] cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= load_val;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// last cycle of the interval, then rests at zero
	assign done = (cnt == timer_w'(1));

endmodule

/* stim_fsm.sv */
//##############################
// stimulation controller
// idle, stim and refractory phases
//##############################

module stim_fsm (
	input logic clk,
	input logic arst_n,
	input logic detect,
	output logic stim
);
	import ctrl_pkg::*;

	// the stim literal is scoped since the output port shares its name
	stim_state_t state;
	stim_state_t state_nxt;
	logic load;
	logic [timer_w-1:0] load_val;
	logic done;

	always_comb begin
		state_nxt = state;
		load = 1'b0;
		load_val = timer_w'(stim_cyc);
		case (state)
			idle: begin
				if (detect) begin
					state_nxt = ctrl_pkg::stim;
					load = 1'b1;
				end
			end
			ctrl_pkg::stim: begin
				if (done) begin
					state_nxt = refract;
					load = 1'b1;
					load_val = timer_w'(refract_cyc);
				end
			end
			refract: begin
				// detects here are ignored
				if (done)
					state_nxt = idle;
			end
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			stim <= 1'b0;
		end else begin
			state <= state_nxt;
			stim <= (state_nxt == ctrl_pkg::stim);
		end
	end

	stim_timer stim_timer_i (
		.clk(clk),
		.arst_n(arst_n),
		.load(load),
		.load_val(load_val),
		.done(done)
	);

endmodule

/* seizure_datapath.sv */
//##############################
// seizure detection top level
// features, baselines, vote, stim
//##############################

module seizure_datapath (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic signed [feat_pkg::sample_w-1:0] sample,
	output feat_pkg::feat_vec_t feat,
	output logic feat_valid,
	output logic detect,
	output logic stim
);
	import feat_pkg::*;

	feat_flags_t flags;
	logic flags_valid;

	feature_extract feature_extract_i (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.sample(sample),
		.feat(feat),
		.feat_valid(feat_valid)
	);

	baseline_track baseline_track_i (
		.clk(clk),
		.arst_n(arst_n),
		.feat(feat),
		.feat_valid(feat_valid),
		.flags(flags),
		.flags_valid(flags_valid)
	);

	feature_vote feature_vote_i (
		.clk(clk),
		.arst_n(arst_n),
		.flags(flags),
		.flags_valid(flags_valid),
		.detect(detect)
	);

	// closed loop, detect drives the stimulator
	stim_fsm stim_fsm_i (
		.clk(clk),
		.arst_n(arst_n),
		.detect(detect),
		.stim(stim)
	);

endmodule

/* tb_clock.sv */
//##############################
// testbench clock, period 40
//##############################

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

endmodule

/* seizure_asserts.sv */
//##############################
// output protocol checks
// pulse widths and stim length
//##############################

module seizure_asserts (
	input logic clk,
	input logic arst_n,
	input logic feat_valid,
	input logic detect,
	input logic stim
);
	import ctrl_pkg::*;

	// length of the current stim high run
	logic [timer_w-1:0] run;

	// count of failed properties
	int fail_cnt = 0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= '0;
		end else if (stim) begin
			run <= run + 1'b1;
		end else begin
			run <= '0;
		end
	end

	feat_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		feat_valid |=> !feat_valid)
		else begin
			fail_cnt++;
			$error("feat_valid high for more than one cycle");
		end

	detect_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		detect |=> !detect)
		else begin
			fail_cnt++;
			$error("detect high for more than one cycle");
		end

	stim_run_len: assert property (@(posedge clk) disable iff (!arst_n)
		run <= timer_w'(stim_cyc))
		else begin
			fail_cnt++;
			$error("stim high longer than the pulse length");
		end

	stim_in_reset: assert property (@(posedge clk) !arst_n |-> !stim)
		else begin
			fail_cnt++;
			$error("stim high during reset");
		end

endmodule

/* seizure_tb.sv */
//##############################
// seizure datapath testbench
// file driven windows, stim model
//##############################

module seizure_tb;
	import feat_pkg::*;
	import ctrl_pkg::*;

	localparam int max_win = 32;

	logic clk;
	logic arst_n;
	logic en;
	logic signed [sample_w-1:0] sample;
	feat_vec_t feat;
	logic feat_valid;
	logic detect;
	logic stim;

	int samples [max_win][feat_win];
	longint exp_ll [max_win];
	longint exp_ne [max_win];
	longint exp_pw [max_win];
	int exp_det [max_win];
	int n_win;

	// pending output events, cycle and window index
	int fv_cyc_q[$];
	int fv_win_q[$];
	int det_cyc_q[$];
	int det_win_q[$];

	int cyc;
	int seed;
	stim_state_t m_state;
	int m_left;

	tb_clock tb_clock_i (.clk(clk));

	seizure_datapath seizure_datapath_i (
		.clk(clk),
		.arst_n(arst_n),
		.en(en),
		.sample(sample),
		.feat(feat),
		.feat_valid(feat_valid),
		.detect(detect),
		.stim(stim)
	);

	bind seizure_datapath seizure_asserts seizure_asserts_i (
		.clk(clk),
		.arst_n(arst_n),
		.feat_valid(feat_valid),
		.detect(detect),
		.stim(stim)
	);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input longint got, input longint exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic load_windows();
		int fd;
		int n;
		string line;
		int s [feat_win];
		longint ll;
		longint ne;
		longint pw;
		int det;
		fd = $fopen("seizure_testdata.txt", "r");
		if (fd == 0)
			stop_run("could not open the test data file");
		n_win = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7],
				s[8], s[9], s[10], s[11], s[12], s[13], s[14], s[15],
				ll, ne, pw, det);
			if (n != 20)
				stop_run("a test data line has the wrong number of fields");
			for (int i = 0; i < feat_win; i++)
				samples[n_win][i] = s[i];
			exp_ll[n_win] = ll;
			exp_ne[n_win] = ne;
			exp_pw[n_win] = pw;
			exp_det[n_win] = det;
			n_win++;
		end
		$fclose(fd);
		if (n_win == 0)
			stop_run("the test data file holds no windows");
	endtask

	// compare outputs against pending events and the stim model
	task automatic check_outputs();
		int w;
		if (seizure_datapath_i.seizure_asserts_i.fail_cnt != 0)
			stop_run("a bound protocol assertion failed");
		if (fv_cyc_q.size() > 0 && fv_cyc_q[0] == cyc) begin
			void'(fv_cyc_q.pop_front());
			w = fv_win_q.pop_front();
			check_value("feat_valid", longint'(feat_valid), 1);
			check_value("feat.ll", longint'(feat.ll), exp_ll[w]);
			check_value("feat.ne", longint'($signed(feat.ne)), exp_ne[w]);
			check_value("feat.pw", longint'(feat.pw), exp_pw[w]);
		end else begin
			check_value("feat_valid idle", longint'(feat_valid), 0);
		end
		if (det_cyc_q.size() > 0 && det_cyc_q[0] == cyc) begin
			void'(det_cyc_q.pop_front());
			w = det_win_q.pop_front();
			if (w < warmup_win)
				check_value("detect in warm-up", longint'(detect), 0);
			check_value("detect", longint'(detect), exp_det[w]);
		end else begin
			check_value("detect idle", longint'(detect), 0);
		end
		check_value("stim", longint'(stim), (m_state == ctrl_pkg::stim) ? 1 : 0);
		// step the controller model with this cycle's detect
		case (m_state)
			idle: begin
				if (detect && arst_n) begin
					m_state = ctrl_pkg::stim;
					m_left = stim_cyc;
				end
			end
			ctrl_pkg::stim: begin
				m_left--;
				if (m_left == 0) begin
					m_state = refract;
					m_left = refract_cyc;
				end
			end
			default: begin
				m_left--;
				if (m_left == 0)
					m_state = idle;
			end
		endcase
	endtask

	task automatic next_cycle();
		@(negedge clk);
		cyc++;
		check_outputs();
	endtask

	task automatic drive_window(input int w);
		int gap;
		for (int i = 0; i < feat_win; i++) begin
			gap = $unsigned($random(seed)) % 3;
			for (int g = 0; g < gap; g++) begin
				next_cycle();
				en = 1'b0;
			end
			next_cycle();
			en = 1'b1;
			sample = sample_w'(samples[w][i]);
			if (i == feat_win - 1) begin
				fv_cyc_q.push_back(cyc + 1);
				fv_win_q.push_back(w);
				det_cyc_q.push_back(cyc + 3);
				det_win_q.push_back(w);
			end
		end
	endtask

	initial begin
		int guard;
		arst_n = 1'b0;
		en = 1'b0;
		sample = '0;
		cyc = 0;
		seed = 32'h7b6b_a7b4;
		m_state = idle;
		m_left = 0;
		load_windows();
		repeat (10) next_cycle();
		arst_n = 1'b1;
		for (int w = 0; w < n_win; w++)
			drive_window(w);
		next_cycle();
		en = 1'b0;
		// drain the pipeline and the controller
		guard = 0;
		while (fv_cyc_q.size() > 0 || det_cyc_q.size() > 0 || m_state != idle) begin
			if (guard > 200)
				stop_run("timed out waiting for the outputs to settle");
			guard++;
			next_cycle();
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* seizure_testdata.txt */
# columns: 16 signed samples, expected ll ne pw, expected detect
# windows alternate +a and -a, history carries over from the previous window
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 310 100 1600 0
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 320 0 1600 0
200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 6210 36100 640000 0
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 510 36100 1600 0
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 320 0 1600 0
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 320 0 1600 0
200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 6210 36100 640000 1
200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 200 -200 6400 0 640000 1
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 510 36100 1600 0
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 320 0 1600 0
300 -300 300 -300 300 -300 300 -300 300 -300 300 -300 300 -300 300 -300 9310 84100 1440000 1
10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 10 -10 610 84100 1600 0

/* all.f */
feat_pkg.sv
ctrl_pkg.sv
feature_extract.sv
baseline_track.sv
feature_vote.sv
stim_timer.sv
stim_fsm.sv
seizure_datapath.sv
tb_clock.sv
seizure_asserts.sv
seizure_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module seizure_tb -o seizure_sim
	./obj_dir/seizure_sim

clean:
	rm -rf obj_dir
